//--- ep_pkg.sv
// Endpoint shared definitions
// Widths, TLP format and type codes, the identity word and the
// common DWord, index, byte-enable and ID types used across the
// receive, register and transmit blocks.

`default_nettype none

package ep_pkg;

    // ----------------------------------------------------------------------
    // Widths and sizes
    // ----------------------------------------------------------------------
    localparam int DATA_W     = 32;    // LocalLink DWord
    localparam int REG_ADDR_W = 5;     // DWord index into the register file
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // ----------------------------------------------------------------------
    // TLP format and type, bits [30:24] of header DWord 0
    // ----------------------------------------------------------------------
    localparam logic [6:0] FMT_TYPE_MRD32 = 7'b00_00000;  // 3DW, no data
    localparam logic [6:0] FMT_TYPE_MWR32 = 7'b10_00000;  // 3DW, with data
    localparam logic [6:0] FMT_TYPE_CPLD  = 7'b10_01010;  // Completion with data

    // Returned by register 0 regardless of writes
    localparam logic [DATA_W-1:0] ID_REG_VALUE = 32'hE9D0_0001;

    // ----------------------------------------------------------------------
    // Shared types
    // ----------------------------------------------------------------------
    typedef logic [DATA_W-1:0]     tlp_dw_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            byte_en_t;   // Bit 0 is the lowest address byte
    typedef logic [15:0]           req_id_t;    // Bus, device, function

endpackage

`default_nettype wire

//--- ep_cpl_req_if.sv
// Completion request channel
// The receive engine posts a read request here and holds it until the
// transmit engine reports that the completion has left.

`default_nettype none

interface ep_cpl_req_if import ep_pkg::*; ();

    logic      req_compl;   // Level, held until compl_done
    logic      compl_done;  // Pulse on last accepted beat
    logic [2:0] req_tc;
    logic [1:0] req_attr;
    req_id_t   req_rid;
    logic [7:0] req_tag;
    byte_en_t  req_be;      // First DWord byte enables
    reg_addr_t req_addr;

    modport rx_mp (
        output req_compl, req_tc, req_attr, req_rid, req_tag, req_be, req_addr,
        input  compl_done
    );

    modport tx_mp (
        input  req_compl, req_tc, req_attr, req_rid, req_tag, req_be, req_addr,
        output compl_done
    );

endinterface

`default_nettype wire

//--- ep_mem_wr_if.sv
// Register file write channel
// One-cycle write strobe with address, byte enables and data, plus the
// busy flag that the register block returns after each write.

`default_nettype none

interface ep_mem_wr_if import ep_pkg::*; ();

    logic      wr_en;       // Only while wr_busy is low
    reg_addr_t wr_addr;
    byte_en_t  wr_be;
    tlp_dw_t   wr_data;     // Byte 0 in bits [7:0]
    logic      wr_busy;

    modport rx_mp (
        output wr_en, wr_addr, wr_be, wr_data,
        input  wr_busy
    );

    modport mem_mp (
        input  wr_en, wr_addr, wr_be, wr_data,
        output wr_busy
    );

endinterface

`default_nettype wire

//--- ep_rx_engine.sv
// Receive engine
// Walks incoming LocalLink TLPs beat by beat. One-DWord memory writes go
// to the register file write port, one-DWord memory reads become a
// completion request. Everything else is drained to end of frame.
// Back-pressure is applied while a completion is pending or a write
// is still settling.

`default_nettype none

module ep_rx_engine import ep_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire tlp_dw_t trn_rd_i,
    input  wire logic    trn_rsof_n_i,
    input  wire logic    trn_reof_n_i,
    input  wire logic    trn_rsrc_rdy_n_i,
    output logic         trn_rdst_rdy_n_o,
    ep_cpl_req_if.rx_mp  cpl_req,
    ep_mem_wr_if.rx_mp   mem_wr
);

    typedef enum logic [2:0] {
        RX_DW0,     // Waiting for start of frame
        RX_DW1,     // Requester ID, tag, byte enables
        RX_DW2,     // Address
        RX_DATA,    // Write payload
        RX_SKIP     // Drain unsupported TLP
    } rx_state_e;

    rx_state_e  state;
    logic       is_wr_q;
    logic       req_compl_q;
    logic       wr_en_q;
    logic       beat_ok;
    logic [6:0] fmt_type;
    logic       one_dw;

    logic [2:0] tc_q;
    logic [1:0] attr_q;
    req_id_t    rid_q;
    logic [7:0] tag_q;
    byte_en_t   be_q;
    reg_addr_t  addr_q;
    tlp_dw_t    wr_data_q;

    assign beat_ok  = !trn_rsrc_rdy_n_i && !trn_rdst_rdy_n_o;
    assign fmt_type = trn_rd_i[30:24];
    assign one_dw   = (trn_rd_i[9:0] == 10'd1);

    // Stall while a completion is owed or the register file is busy
    assign trn_rdst_rdy_n_o = req_compl_q || mem_wr.wr_busy;

    // ----------------------------------------------------------------------
    // Beat-count FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_DW0;
            is_wr_q     <= 1'b0;
            req_compl_q <= 1'b0;
            wr_en_q     <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (cpl_req.compl_done)
                req_compl_q <= 1'b0;

            if (beat_ok) begin
                case (state)
                    RX_DW0: begin
                        if (!trn_rsof_n_i && trn_reof_n_i) begin
                            if (one_dw && fmt_type == FMT_TYPE_MRD32) begin
                                is_wr_q <= 1'b0;
                                state   <= RX_DW1;
                            end else if (one_dw && fmt_type == FMT_TYPE_MWR32) begin
                                is_wr_q <= 1'b1;
                                state   <= RX_DW1;
                            end else begin
                                state <= RX_SKIP;
                            end
                        end
                    end
                    RX_DW1: state <= trn_reof_n_i ? RX_DW2 : RX_DW0;
                    RX_DW2: begin
                        if (!trn_reof_n_i) begin
                            state <= RX_DW0;
                            if (!is_wr_q)
                                req_compl_q <= 1'b1;    // Read complete
                        end else begin
                            state <= is_wr_q ? RX_DATA : RX_SKIP;
                        end
                    end
                    RX_DATA: begin
                        wr_en_q <= 1'b1;
                        state   <= trn_reof_n_i ? RX_SKIP : RX_DW0;
                    end
                    RX_SKIP: if (!trn_reof_n_i) state <= RX_DW0;
                    default: state <= RX_DW0;
                endcase
            end
        end
    end

    // Header fields and write payload
    always_ff @(posedge clk) begin
        if (beat_ok) begin
            case (state)
                RX_DW0: begin
                    tc_q   <= trn_rd_i[22:20];
                    attr_q <= trn_rd_i[13:12];
                end
                RX_DW1: begin
                    rid_q <= trn_rd_i[31:16];
                    tag_q <= trn_rd_i[15:8];
                    be_q  <= trn_rd_i[3:0];     // First DW BE only
                end
                RX_DW2:  addr_q    <= trn_rd_i[REG_ADDR_W+1:2];
                RX_DATA: wr_data_q <= {<<8{trn_rd_i}};  // LocalLink is big-endian
                default: ;
            endcase
        end
    end

    assign cpl_req.req_compl = req_compl_q;
    assign cpl_req.req_tc    = tc_q;
    assign cpl_req.req_attr  = attr_q;
    assign cpl_req.req_rid   = rid_q;
    assign cpl_req.req_tag   = tag_q;
    assign cpl_req.req_be    = be_q;
    assign cpl_req.req_addr  = addr_q;

    assign mem_wr.wr_en   = wr_en_q;
    assign mem_wr.wr_addr = addr_q;
    assign mem_wr.wr_be   = be_q;
    assign mem_wr.wr_data = wr_data_q;

    // Write strobe must respect the register file's busy cycle
    a_wr_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_wr.wr_en && mem_wr.wr_busy));

endmodule

`default_nettype wire

//--- ep_mem_access.sv
// Endpoint register file
// 32 DWords written through per-byte enables. Register 0 is a
// read-only identity word. Reads are registered and mask the bytes
// that were not requested. A busy flag covers the cycle after a write.

`default_nettype none

module ep_mem_access import ep_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    ep_mem_wr_if.mem_mp    mem_wr,
    input  wire reg_addr_t rd_addr_i,
    input  wire byte_en_t  rd_be_i,
    output tlp_dw_t        rd_data_o
);

    tlp_dw_t regs [NUM_REGS];
    logic    wr_busy_q;
    tlp_dw_t rd_word;
    tlp_dw_t be_mask;

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
            wr_busy_q <= 1'b0;
        end else begin
            wr_busy_q <= mem_wr.wr_en;
            // Identity register is not writable
            if (mem_wr.wr_en && mem_wr.wr_addr != '0) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_wr.wr_be[b])
                        regs[mem_wr.wr_addr][8*b +: 8] <= mem_wr.wr_data[8*b +: 8];
                end
            end
        end
    end

    assign mem_wr.wr_busy = wr_busy_q;

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------
    assign rd_word = (rd_addr_i == '0) ? ID_REG_VALUE : regs[rd_addr_i];

    assign be_mask = {{8{rd_be_i[3]}}, {8{rd_be_i[2]}},
                      {8{rd_be_i[1]}}, {8{rd_be_i[0]}}};

    always_ff @(posedge clk) begin
        rd_data_o <= rd_word & be_mask;     // Valid one cycle after address
    end

    // One busy cycle per write, never back to back
    a_busy_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr.wr_busy |=> !mem_wr.wr_busy);

endmodule

`default_nettype wire

//--- ep_tx_engine.sv
// Transmit engine
// Answers a pending read with a four-beat completion with data:
// three header DWords followed by the register contents. One cycle
// reads the register file, the next loads the first header beat.
// Beats and strobes hold while the link applies back-pressure.

`default_nettype none

module ep_tx_engine import ep_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    output tlp_dw_t        trn_td_o,
    output logic           trn_tsof_n_o,
    output logic           trn_teof_n_o,
    output logic           trn_tsrc_rdy_n_o,
    input  wire logic      trn_tdst_rdy_n_i,
    input  wire req_id_t   cfg_completer_id_i,
    ep_cpl_req_if.tx_mp    cpl_req,
    output reg_addr_t      rd_addr_o,
    output byte_en_t       rd_be_o,
    input  wire tlp_dw_t   rd_data_i
);

    typedef enum logic [1:0] {TX_IDLE, TX_READ, TX_SEND} tx_state_e;

    tx_state_e   state;
    logic [1:0]  beat_q;
    logic [1:0]  nxt_idx;
    logic        beat_ok;
    tlp_dw_t     data_q;
    tlp_dw_t     nxt_beat;
    logic [1:0]  lo_idx;
    logic [1:0]  hi_idx;
    logic [11:0] byte_cnt;
    logic [6:0]  lower_addr;

    assign rd_addr_o = cpl_req.req_addr;
    assign rd_be_o   = cpl_req.req_be;

    assign beat_ok = !trn_tsrc_rdy_n_o && !trn_tdst_rdy_n_i;
    assign nxt_idx = (state == TX_READ) ? 2'd0 : beat_q + 2'd1;

    assign cpl_req.compl_done = beat_ok && !trn_teof_n_o;

    // ----------------------------------------------------------------------
    // Byte count and lower address from the first DW byte enables
    // ----------------------------------------------------------------------
    always_comb begin
        casez (cpl_req.req_be)
            4'b???1: lo_idx = 2'd0;
            4'b??10: lo_idx = 2'd1;
            4'b?100: lo_idx = 2'd2;
            4'b1000: lo_idx = 2'd3;
            default: lo_idx = 2'd0;
        endcase
        casez (cpl_req.req_be)
            4'b1???: hi_idx = 2'd3;
            4'b01??: hi_idx = 2'd2;
            4'b001?: hi_idx = 2'd1;
            default: hi_idx = 2'd0;
        endcase
    end

    assign byte_cnt   = (cpl_req.req_be == '0) ? 12'd1 :
                        12'(hi_idx) - 12'(lo_idx) + 12'd1;
    assign lower_addr = {cpl_req.req_addr, 2'b00} + 7'(lo_idx);

    // Next beat to load onto the link
    always_comb begin
        case (nxt_idx)
            2'd0: nxt_beat = {1'b0, FMT_TYPE_CPLD, 1'b0, cpl_req.req_tc, 4'b0000,
                              1'b0, 1'b0, cpl_req.req_attr, 2'b00, 10'd1};
            2'd1: nxt_beat = {cfg_completer_id_i, 3'b000, 1'b0, byte_cnt}; // Status SC
            2'd2: nxt_beat = {cpl_req.req_rid, cpl_req.req_tag, 1'b0, lower_addr};
            default: nxt_beat = {<<8{data_q}};    // Back to LocalLink byte order
        endcase
    end

    // ----------------------------------------------------------------------
    // Completion FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state            <= TX_IDLE;
            beat_q           <= 2'd0;
            trn_tsrc_rdy_n_o <= 1'b1;
            trn_tsof_n_o     <= 1'b1;
            trn_teof_n_o     <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: if (cpl_req.req_compl) state <= TX_READ;
                TX_READ: begin
                    state            <= TX_SEND;
                    beat_q           <= nxt_idx;
                    trn_tsrc_rdy_n_o <= 1'b0;
                    trn_tsof_n_o     <= 1'b0;
                    trn_teof_n_o     <= 1'b1;
                end
                TX_SEND: begin
                    if (beat_ok) begin
                        trn_tsof_n_o <= 1'b1;
                        if (!trn_teof_n_o) begin
                            state            <= TX_IDLE;
                            trn_tsrc_rdy_n_o <= 1'b1;
                            trn_teof_n_o     <= 1'b1;
                        end else begin
                            beat_q       <= nxt_idx;
                            trn_teof_n_o <= (nxt_idx != 2'd3);
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == TX_READ)
            data_q <= rd_data_i;
        if (state == TX_READ || (state == TX_SEND && beat_ok && trn_teof_n_o))
            trn_td_o <= nxt_beat;
    end

    a_strobe_framing: assert property (@(posedge clk) disable iff (!rst_n)
        (!trn_tsof_n_o || !trn_teof_n_o) |-> !trn_tsrc_rdy_n_o);

endmodule

`default_nettype wire

//--- ep_top.sv
// PCI Express endpoint target
// Receive engine, register file and transmit engine joined on a
// 32-bit LocalLink interface. Serves one-DWord memory reads and
// writes to a 32-entry register file.

`default_nettype none

module ep_top import ep_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,

    // LocalLink receive
    input  wire tlp_dw_t trn_rd_i,
    input  wire logic    trn_rsof_n_i,
    input  wire logic    trn_reof_n_i,
    input  wire logic    trn_rsrc_rdy_n_i,
    output logic         trn_rdst_rdy_n_o,

    // LocalLink transmit
    output tlp_dw_t      trn_td_o,
    output logic         trn_tsof_n_o,
    output logic         trn_teof_n_o,
    output logic         trn_tsrc_rdy_n_o,
    input  wire logic    trn_tdst_rdy_n_i,

    input  wire req_id_t cfg_completer_id_i
);

    // Register file read port
    reg_addr_t rd_addr;
    byte_en_t  rd_be;
    tlp_dw_t   rd_data;

    ep_cpl_req_if cpl_req_bus ();
    ep_mem_wr_if  mem_wr_bus ();

    ep_rx_engine i_rx (
        .clk              (clk),
        .rst_n            (rst_n),
        .trn_rd_i         (trn_rd_i),
        .trn_rsof_n_i     (trn_rsof_n_i),
        .trn_reof_n_i     (trn_reof_n_i),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n_i),
        .trn_rdst_rdy_n_o (trn_rdst_rdy_n_o),
        .cpl_req          (cpl_req_bus.rx_mp),
        .mem_wr           (mem_wr_bus.rx_mp)
    );

    ep_mem_access i_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_wr    (mem_wr_bus.mem_mp),
        .rd_addr_i (rd_addr),
        .rd_be_i   (rd_be),
        .rd_data_o (rd_data)
    );

    ep_tx_engine i_tx (
        .clk                (clk),
        .rst_n              (rst_n),
        .trn_td_o           (trn_td_o),
        .trn_tsof_n_o       (trn_tsof_n_o),
        .trn_teof_n_o       (trn_teof_n_o),
        .trn_tsrc_rdy_n_o   (trn_tsrc_rdy_n_o),
        .trn_tdst_rdy_n_i   (trn_tdst_rdy_n_i),
        .cfg_completer_id_i (cfg_completer_id_i),
        .cpl_req            (cpl_req_bus.tx_mp),
        .rd_addr_o          (rd_addr),
        .rd_be_o            (rd_be),
        .rd_data_i          (rd_data)
    );

endmodule

`default_nettype wire

//--- tb_ep_checker.sv
// Completion checker
// Watches the endpoint's transmit LocalLink port, gathers each accepted
// completion and compares it beat by beat with the oldest expected one.
// Also checks the link strobes after reset and keeps the cycle budget
// of the run.

`default_nettype none

module tb_ep_checker import ep_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire tlp_dw_t trn_td_i,
    input  wire logic    trn_tsof_n_i,
    input  wire logic    trn_teof_n_i,
    input  wire logic    trn_tsrc_rdy_n_i,
    input  wire logic    trn_tdst_rdy_n_i,
    input  wire logic    trn_rdst_rdy_n_i,
    output logic         idle_o,
    output logic         timed_out_o,
    output int           errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [127:0] exp_q [$];        // Beat 0 in the top bits
    tlp_dw_t      beats [4];
    int           n_beats   = 0;
    logic         in_frame  = 1'b0;
    int           pushed    = 0;
    int           popped    = 0;
    int           errors    = 0;
    int           tlp_cnt   = 0;
    int           cycles    = 0;
    logic         timed_out = 1'b0;

    assign idle_o      = (pushed == popped) && !in_frame;
    assign timed_out_o = timed_out;
    assign errors_o    = errors;

    task push_expected(input logic [127:0] cpl);
        exp_q.push_back(cpl);
        pushed++;
    endtask

    task note_tlp();
        tlp_cnt++;      // Widens the cycle budget
    endtask

    task report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s after reset: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Frame compare
    // ----------------------------------------------------------------------
    task automatic check_frame();
        logic [127:0] exp;
        tlp_dw_t      want;
        if (exp_q.size() == 0) begin
            report_error("completion arrived when none was expected");
        end else begin
            exp = exp_q.pop_front();
            popped++;
            if (n_beats != 4)
                report_error($sformatf("completion had %0d beats instead of 4", n_beats));
            for (int i = 0; i < 4 && i < n_beats; i++) begin
                want = exp[127-32*i -: 32];
                if (beats[i] !== want) begin
                    $display("FAIL trn_td_o beat %0d: got %08h, expected %08h",
                             i, beats[i], want);
                    errors++;
                end
            end
        end
    endtask

    // Idle strobes just after reset release, before any edge moves them
    always @(posedge rst_n) begin
        @(negedge clk);
        check_level("trn_tsrc_rdy_n_o", trn_tsrc_rdy_n_i, 1'b1);
        check_level("trn_tsof_n_o", trn_tsof_n_i, 1'b1);
        check_level("trn_teof_n_o", trn_teof_n_i, 1'b1);
        check_level("trn_rdst_rdy_n_o", trn_rdst_rdy_n_i, 1'b0);
    end

    // Strobes and data are registered, stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            in_frame = 1'b0;
            n_beats  = 0;
        end else if (!trn_tsrc_rdy_n_i && !trn_tdst_rdy_n_i) begin
            if (!trn_tsof_n_i) begin
                if (in_frame)
                    report_error("completion restarted before its end strobe");
                in_frame = 1'b1;
                n_beats  = 0;
            end else if (!in_frame) begin
                report_error("completion beat seen without a start strobe");
            end
            if (in_frame) begin
                if (n_beats < 4)
                    beats[n_beats] = trn_td_i;
                n_beats++;
                if (!trn_teof_n_i) begin
                    check_frame();
                    in_frame = 1'b0;
                end else if (n_beats == 4) begin
                    report_error("completion has no end strobe on its fourth beat");
                    check_frame();
                    in_frame = 1'b0;
                end
            end
        end
    end

    // Cycle budget, 200 per issued TLP plus 100
    always @(posedge clk) begin
        cycles++;
        if (!timed_out && cycles > 200 * tlp_cnt + 100) begin
            $display("ERROR: run timed out after %0d cycles, %0d completions outstanding",
                     cycles, pushed - popped);
            timed_out <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb_ep.sv
// Endpoint testbench
// Sends one-DWord memory writes and reads to the endpoint over LocalLink,
// keeps a shadow register file and passes each expected completion to
// the checker. Runs six tests in order and prints a summary.

`default_nettype none

module tb_ep import ep_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam req_id_t completer_id = 16'h0208;
    localparam req_id_t writer_id    = 16'h0100;

    logic    clk;
    logic    rst_n;
    tlp_dw_t trn_rd;
    logic    trn_rsof_n;
    logic    trn_reof_n;
    logic    trn_rsrc_rdy_n;
    logic    trn_rdst_rdy_n;
    tlp_dw_t trn_td;
    logic    trn_tsof_n;
    logic    trn_teof_n;
    logic    trn_tsrc_rdy_n;
    logic    trn_tdst_rdy_n = 1'b0;

    tlp_dw_t   shadow [NUM_REGS];       // Register contents, byte 0 in [7:0]
    int        seed;
    int        rnd;
    int        bp_rnd;
    logic      bp_on;
    reg_addr_t addr;
    int        tests_pass;
    int        tests_fail;
    int        errs_at_start;
    logic      chk_idle;
    logic      timed_out;
    int        chk_errors;

    ep_top i_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .trn_rd_i           (trn_rd),
        .trn_rsof_n_i       (trn_rsof_n),
        .trn_reof_n_i       (trn_reof_n),
        .trn_rsrc_rdy_n_i   (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n_o   (trn_rdst_rdy_n),
        .trn_td_o           (trn_td),
        .trn_tsof_n_o       (trn_tsof_n),
        .trn_teof_n_o       (trn_teof_n),
        .trn_tsrc_rdy_n_o   (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n_i   (trn_tdst_rdy_n),
        .cfg_completer_id_i (completer_id)
    );

    tb_ep_checker i_chk (
        .clk              (clk),
        .rst_n            (rst_n),
        .trn_td_i         (trn_td),
        .trn_tsof_n_i     (trn_tsof_n),
        .trn_teof_n_i     (trn_teof_n),
        .trn_tsrc_rdy_n_i (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n_i (trn_tdst_rdy_n),
        .trn_rdst_rdy_n_i (trn_rdst_rdy_n),
        .idle_o           (chk_idle),
        .timed_out_o      (timed_out),
        .errors_o         (chk_errors)
    );

    always #20 clk = ~clk;

    // Random back-pressure on the transmit side
    always @(posedge clk) begin
        #2;
        if (bp_on) begin
            bp_rnd = $random(seed);
            trn_tdst_rdy_n = bp_rnd[0];
        end else begin
            trn_tdst_rdy_n = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (timed_out) begin
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic tlp_dw_t swap_bytes(input tlp_dw_t d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};   // LocalLink lane order
    endfunction

    function automatic tlp_dw_t make_dw0(input logic [6:0] fmt, input logic [2:0] tc,
                                         input logic [1:0] attr);
        return {1'b0, fmt, 1'b0, tc, 4'b0000, 2'b00, attr, 2'b00, 10'd1};
    endfunction

    // Four completion DWords, beat 0 in the top bits
    function automatic logic [127:0] exp_cpl(input tlp_dw_t data, input reg_addr_t a,
                                             input byte_en_t be, input logic [7:0] tag,
                                             input req_id_t rid, input req_id_t cid,
                                             input logic [2:0] tc, input logic [1:0] attr);
        int          lo;
        int          hi;
        logic [11:0] bcnt;
        logic [6:0]  laddr;
        tlp_dw_t     masked;
        lo = 0;
        hi = 0;
        masked = '0;
        for (int b = 3; b >= 0; b--) begin
            if (be[b])
                lo = b;     // Lowest enabled byte wins
        end
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                hi = b;
                masked[8*b +: 8] = data[8*b +: 8];
            end
        end
        bcnt  = (be == 4'h0) ? 12'd1 : 12'(hi - lo + 1);
        laddr = {a, 2'b00} + 7'(lo);
        return {make_dw0(FMT_TYPE_CPLD, tc, attr),
                cid, 3'b000, 1'b0, bcnt,
                rid, tag, 1'b0, laddr,
                swap_bytes(masked)};
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic send_beat(input tlp_dw_t dw, input logic sof, input logic eof);
        logic ok;
        trn_rd         = dw;
        trn_rsof_n     = !sof;
        trn_reof_n     = !eof;
        trn_rsrc_rdy_n = 1'b0;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = !trn_rdst_rdy_n;   // Registered inside the DUT, stable here
            @(posedge clk);
            #2;
        end
    endtask

    task automatic mem_write(input reg_addr_t a, input byte_en_t be, input tlp_dw_t value);
        i_chk.note_tlp();
        send_beat(make_dw0(FMT_TYPE_MWR32, 3'd0, 2'd0), 1'b1, 1'b0);
        send_beat({writer_id, 8'h00, 4'h0, be}, 1'b0, 1'b0);
        send_beat({25'd0, a, 2'b00}, 1'b0, 1'b0);
        send_beat(swap_bytes(value), 1'b0, 1'b1);
        if (a != '0) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    shadow[a][8*b +: 8] = value[8*b +: 8];
            end
        end
    endtask

    task automatic mem_read(input reg_addr_t a, input byte_en_t be, input logic [7:0] tag);
        int         r;
        req_id_t    rid;
        logic [2:0] tc;
        logic [1:0] attr;
        r    = $random(seed);
        rid  = r[15:0];
        tc   = r[18:16];
        attr = r[21:20];
        i_chk.note_tlp();
        i_chk.push_expected(exp_cpl(shadow[a], a, be, tag, rid, completer_id, tc, attr));
        send_beat(make_dw0(FMT_TYPE_MRD32, tc, attr), 1'b1, 1'b0);
        send_beat({rid, tag, 4'h0, be}, 1'b0, 1'b0);
        send_beat({25'd0, a, 2'b00}, 1'b0, 1'b1);
    endtask

    // 4DW memory read header, not served by the endpoint
    task automatic send_unsupported();
        i_chk.note_tlp();
        send_beat(make_dw0(7'b01_00000, 3'd0, 2'd0), 1'b1, 1'b0);
        send_beat({writer_id, 8'h55, 4'h0, 4'hf}, 1'b0, 1'b0);
        send_beat(32'h0000_0001, 1'b0, 1'b0);
        send_beat(32'h0000_0040, 1'b0, 1'b1);
    endtask

    task automatic end_test(input string name);
        trn_rsrc_rdy_n = 1'b1;
        while (!chk_idle) begin
            @(posedge clk);
            #2;
        end
        repeat (4) @(posedge clk);
        #2;
        if (chk_errors == errs_at_start) begin
            $display("test %s: ok", name);
            tests_pass++;
        end else begin
            $display("test %s: failed with %0d errors", name, chk_errors - errs_at_start);
            tests_fail++;
        end
        errs_at_start = chk_errors;
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        seed           = 32'hfbea;
        clk            = 1'b0;
        rst_n          = 1'b0;
        trn_rd         = '0;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        bp_on          = 1'b0;
        tests_pass     = 0;
        tests_fail     = 0;
        errs_at_start  = 0;
        for (int i = 0; i < NUM_REGS; i++)
            shadow[i] = '0;
        shadow[0] = ID_REG_VALUE;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mem_read('0, 4'hf, 8'h01);
        end_test("identity read after reset");

        for (int a = 1; a < NUM_REGS; a++) begin
            mem_write(reg_addr_t'(a), 4'hf, $random(seed));
            mem_read(reg_addr_t'(a), 4'hf, 8'(a));
        end
        end_test("full word writes and reads");

        for (int i = 0; i < 12; i++) begin
            rnd  = $random(seed);
            addr = reg_addr_t'(1 + (rnd[15:8] % 31));
            mem_write(addr, rnd[3:0], $random(seed));
            mem_read(addr, (i == 0) ? 4'h0 : rnd[7:4], 8'(i + 64));
        end
        end_test("partial byte enables");

        mem_write('0, 4'hf, 32'hdead_beef);
        mem_read('0, 4'hf, 8'h80);
        end_test("identity register ignores writes");

        send_unsupported();
        mem_read(reg_addr_t'(7), 4'hf, 8'h90);     // Right behind the discarded TLP
        end_test("unsupported TLP discarded");

        bp_on = 1'b1;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            mem_read(rnd[12:8], rnd[3:0], 8'(i + 160));
        end
        end_test("back-pressure with back-to-back reads");
        bp_on = 1'b0;

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0 && chk_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
ep_pkg.sv
ep_cpl_req_if.sv
ep_mem_wr_if.sv
ep_rx_engine.sv
ep_mem_access.sv
ep_tx_engine.sv
ep_top.sv
tb_ep_checker.sv
tb_ep.sv

//--- Makefile
# Verilator build and run for the endpoint testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_ep
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
